/* build.f */
+incdir+test
hdl/riscv_pkg.sv
hdl/bpu_pkg.sv
hdl/btb.sv
hdl/gshare.sv
hdl/predict_stage.sv
hdl/resolve_stage.sv
hdl/branch_unit.sv
test/branch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the branch unit testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module branch_unit_tb \
    -f build.f -o branch_unit_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/branch_unit_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "Simulation run failed"; exit 1; }

grep -q "Errors found" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || echo "Simulation passed"

/* test/bpu_ref.svh */
// Reference branch predictor model
`ifndef BPU_REF_SVH
`define BPU_REF_SVH

// Expected output plus the lookup state it was predicted with
typedef struct packed {
    logic [31:0]             pc;
    logic                    hit;
    logic [NUM_GHR_BITS-1:0] idx;
    logic                    pred_taken;
    logic [31:0]             pred_target;
    logic                    actual_taken;
    logic [31:0]             actual_target;
    logic                    mispredict;
    logic                    is_branch;
    logic                    is_jal;
    logic                    check_pred;
} exp_rec_t;

// Whole PC kept per entry, so a hit is a compare of all word address bits
logic                    m_valid  [NUM_BTB_ENTRIES];
logic [31:0]             m_pc     [NUM_BTB_ENTRIES];
logic                    m_jump   [NUM_BTB_ENTRIES];
logic [31:0]             m_target [NUM_BTB_ENTRIES];
logic [1:0]              m_ctr    [2 ** NUM_GHR_BITS];
logic [NUM_GHR_BITS-1:0] m_ghr;

task automatic reset_model();
    for (int i = 0; i < NUM_BTB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
    end
    // Weakly not taken
    for (int i = 0; i < 2 ** NUM_GHR_BITS; i++) begin
        m_ctr[i] = 2'b01;
    end
    m_ghr = '0;
endtask

function automatic logic mispredict_rule(input logic pt, input logic [31:0] ptgt,
                                         input logic at, input logic [31:0] atgt);
    return (pt != at) || (pt && at && (ptgt != atgt));
endfunction

// Prediction from the current tables, then the actual outcome
function automatic exp_rec_t predict_resolve(input logic [31:0] pc, input logic [31:0] instr,
                                             input logic cond);
    exp_rec_t    r;
    int unsigned slot;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    slot = (pc >> 2) % NUM_BTB_ENTRIES;
    r = '0;
    r.pc = pc;
    r.idx = pc[NUM_GHR_BITS+1:2] ^ m_ghr;
    r.hit = m_valid[slot] && (m_pc[slot][31:2] == pc[31:2]);
    r.pred_taken = r.hit && (m_jump[slot] || m_ctr[r.idx][1]);
    r.pred_target = r.hit ? m_target[slot] : pc + 32'd4;
    // Immediates gathered straight from the instruction bits
    b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    r.is_branch = (instr[6:0] == 7'b1100011);
    r.is_jal = (instr[6:0] == 7'b1101111);
    r.actual_taken = r.is_jal || (r.is_branch && cond);
    r.actual_target = r.is_branch ? pc + b_imm : (r.is_jal ? pc + j_imm : pc + 32'd4);
    r.mispredict = mispredict_rule(r.pred_taken, r.pred_target, r.actual_taken,
                                   r.actual_target);
    return r;
endfunction

// Same training as the hardware, applied in record order
task automatic train_model(input exp_rec_t r);
    int unsigned slot;
    slot = (r.pc >> 2) % NUM_BTB_ENTRIES;
    if ((r.is_branch || r.is_jal) && r.actual_taken && !r.hit) begin
        m_valid[slot] = 1'b1;
        m_pc[slot] = r.pc;
        m_jump[slot] = r.is_jal;
        m_target[slot] = r.actual_target;
    end
    if (r.is_branch) begin
        if (r.actual_taken && (m_ctr[r.idx] != 2'b11)) begin
            m_ctr[r.idx] = m_ctr[r.idx] + 2'b01;
        end else if (!r.actual_taken && (m_ctr[r.idx] != 2'b00)) begin
            m_ctr[r.idx] = m_ctr[r.idx] - 2'b01;
        end
        m_ghr = {r.actual_taken, m_ghr[NUM_GHR_BITS-1:1]};
    end
endtask

`endif

/* test/branch_unit_tb.sv */
// Branch unit testbench
`timescale 1ns/10ps

module branch_unit_tb;

    localparam int NUM_BTB_ENTRIES = 32;
    localparam int NUM_GHR_BITS    = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_STREAM      = 200;
    // Records over all behaviors
    localparam int NUM_RECORDS     = 3 + 24 + 2 + 8 + NUM_STREAM;
    localparam int CYCLE_LIMIT     = 4 * NUM_RECORDS + RESET_CYCLES + 100;
    localparam logic [31:0] NOP    = 32'h0000_0013;

    logic        clk;
    logic        reset_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] pc_i;
    logic [31:0] instr_i;
    logic        cond_taken_i;
    logic        out_valid_o;
    logic        out_ready_i;
    logic [31:0] out_pc_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        actual_taken_o;
    logic [31:0] actual_target_o;
    logic        mispredict_o;

    `include "bpu_ref.svh"

    exp_rec_t exp_q [$];
    int       errors;
    int       checks;
    int       n_sent;
    int       n_out;
    int       cycles;
    logic     random_ready;

    branch_unit #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .NUM_GHR_BITS    (NUM_GHR_BITS)
    ) i_branch_unit (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .pc_i            (pc_i),
        .instr_i         (instr_i),
        .cond_taken_i    (cond_taken_i),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_pc_o        (out_pc_o),
        .pred_taken_o    (pred_taken_o),
        .pred_target_o   (pred_target_o),
        .actual_taken_o  (actual_taken_o),
        .actual_target_o (actual_target_o),
        .mispredict_o    (mispredict_o)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Branch with rs1 = x1, rs2 = x2 and the offset scattered over the word
    function automatic logic [31:0] encode_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // JAL linking into x1
    function automatic logic [31:0] encode_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // Called just after an edge and returns just after the accepting edge
    task automatic send_record(input logic [31:0] pc, input logic [31:0] instr,
                               input logic cond, input logic check_pred);
        exp_rec_t r;
        r = predict_resolve(pc, instr, cond);
        r.check_pred = check_pred;
        in_valid_i = 1'b1;
        pc_i = pc;
        instr_i = instr;
        cond_taken_i = cond;
        @(posedge clk);
        while (!in_ready_o) begin
            @(posedge clk);
        end
        exp_q.push_back(r);
        n_sent++;
        train_model(r);
        #2;
        in_valid_i = 1'b0;
    endtask

    task automatic wait_for_outputs();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One record in flight keeps the model tables equal to the DUT
    task automatic send_alone(input logic [31:0] pc, input logic [31:0] instr,
                              input logic cond);
        send_record(pc, instr, cond, 1'b1);
        wait_for_outputs();
    endtask

    // Output ready is random only during the stream
    // Mode and draw are taken at the edge, the level is driven after the delay
    always @(posedge clk) begin
        logic use_random;
        logic ready_draw;
        use_random = random_ready;
        ready_draw = ($urandom % 4) != 0;
        #2;
        if (use_random) begin
            out_ready_i = ready_draw;
        end else begin
            out_ready_i = 1'b1;
        end
    end

    // Compare every output transfer with the oldest expected record
    always @(posedge clk) begin
        exp_rec_t r;
        if (!reset_i && out_valid_o && out_ready_i) begin
            n_out++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output at %0t ns for pc %h with no record outstanding",
                         $time, out_pc_o);
            end else begin
                r = exp_q.pop_front();
                check_value("out_pc_o", out_pc_o, r.pc);
                check_value("actual_taken_o", 32'(actual_taken_o), 32'(r.actual_taken));
                check_value("actual_target_o", actual_target_o, r.actual_target);
                if (r.check_pred) begin
                    check_value("pred_taken_o", 32'(pred_taken_o), 32'(r.pred_taken));
                    check_value("pred_target_o", pred_target_o, r.pred_target);
                    check_value("mispredict_o", 32'(mispredict_o), 32'(r.mispredict));
                end else begin
                    // Prediction depends on overlap and only its consistency is known
                    check_value("mispredict_o", 32'(mispredict_o),
                                32'(mispredict_rule(pred_taken_o, pred_target_o,
                                                    actual_taken_o, actual_target_o)));
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d records still expected",
                     cycles, exp_q.size());
            $display("Checks: %0d, records: %0d, errors: %0d", checks, n_sent, errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] pc;
        logic [31:0] instr;
        clk = 1'b0;
        reset_i = 1'b1;
        in_valid_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        cond_taken_i = 1'b0;
        out_ready_i = 1'b1;
        random_ready = 1'b0;
        errors = 0;
        checks = 0;
        n_sent = 0;
        n_out = 0;
        cycles = 0;
        void'($urandom(32'hd78b_0817));
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // Empty tables predict fall-through for any instruction
        check_value("out_valid_o", 32'(out_valid_o), 32'd0);
        send_alone(32'h0000_0040, NOP, 1'b0);
        send_alone(32'h0000_0080, encode_branch(13'h0020), 1'b1);
        send_alone(32'h0000_00c4, encode_jal(21'h00100), 1'b0);

        // Loop branch back by 16 is taken seven times then falls out
        for (int k = 0; k < 24; k++) begin
            send_alone(32'h0000_1000, encode_branch(13'h1ff0), (k % 8) != 7);
        end

        // JAL misses once then hits as a jump
        send_alone(32'h0000_2000, encode_jal(21'h00400), 1'b0);
        send_alone(32'h0000_2000, encode_jal(21'h00400), 1'b0);

        // No allocation for sequential code or untaken branches
        for (int pass = 0; pass < 2; pass++) begin
            send_alone(32'h0000_3000, NOP, 1'b0);
            send_alone(32'h0000_3004, encode_branch(13'h0040), 1'b0);
            send_alone(32'h0000_3008, 32'h00b5_0533, 1'b0);
            send_alone(32'h0000_300c, encode_branch(13'h1fe0), 1'b0);
        end

        // Back-to-back stream with output stalls
        random_ready = 1'b1;
        for (int k = 0; k < NUM_STREAM; k++) begin
            pc = 32'h0000_4000 + {24'd0, 6'($urandom), 2'b00};
            case ($urandom % 3)
                0: instr = encode_branch(13'($urandom) & 13'h1ffe);
                1: instr = encode_jal(21'($urandom) & 21'h1ffffe);
                // JALR counts as sequential here
                default: instr = {25'($urandom), ($urandom % 2) ? 7'b1100111 : 7'b0010011};
            endcase
            send_record(pc, instr, 1'($urandom), 1'b0);
        end
        random_ready = 1'b0;
        wait_for_outputs();
        repeat (4) @(posedge clk);

        check_value("records out", n_out, n_sent);
        $display("Checks: %0d, records: %0d, errors: %0d", checks, n_sent, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* hdl/branch_unit.sv */
// Branch prediction unit
`timescale 1ns/10ps

module branch_unit #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 4
) (
    input  logic        clk,
    input  logic        reset_i,
    // Record input
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  logic [31:0] pc_i,
    input  logic [31:0] instr_i,
    input  logic        cond_taken_i,
    // Resolved output
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output logic [31:0] out_pc_o,
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    output logic        actual_taken_o,
    output logic [31:0] actual_target_o,
    output logic        mispredict_o
);

    // Forward path
    logic                    p_valid;
    logic                    p_ready;
    logic [31:0]             p_pc;
    logic [31:0]             p_instr;
    logic                    p_cond_taken;
    logic                    p_pred_taken;
    logic [31:0]             p_pred_target;
    logic                    p_btb_hit;
    logic [NUM_GHR_BITS-1:0] p_pht_index;

    // Training path
    logic                    btb_we;
    logic [31:0]             btb_wr_pc;
    bpu_pkg::btb_kind_e      btb_wr_kind;
    logic [31:0]             btb_wr_target;
    logic                    pht_we;
    logic [NUM_GHR_BITS-1:0] pht_wr_index;
    logic                    pht_inc;

    predict_stage #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .NUM_GHR_BITS    (NUM_GHR_BITS)
    ) i_predict_stage (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .pc_i            (pc_i),
        .instr_i         (instr_i),
        .cond_taken_i    (cond_taken_i),
        .p_valid_o       (p_valid),
        .p_ready_i       (p_ready),
        .p_pc_o          (p_pc),
        .p_instr_o       (p_instr),
        .p_cond_taken_o  (p_cond_taken),
        .pred_taken_o    (p_pred_taken),
        .pred_target_o   (p_pred_target),
        .btb_hit_o       (p_btb_hit),
        .pht_index_o     (p_pht_index),
        .btb_we_i        (btb_we),
        .btb_wr_pc_i     (btb_wr_pc),
        .btb_wr_kind_i   (btb_wr_kind),
        .btb_wr_target_i (btb_wr_target),
        .pht_we_i        (pht_we),
        .pht_wr_index_i  (pht_wr_index),
        .pht_inc_i       (pht_inc)
    );

    resolve_stage #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) i_resolve_stage (
        .clk             (clk),
        .reset_i         (reset_i),
        .p_valid_i       (p_valid),
        .p_ready_o       (p_ready),
        .p_pc_i          (p_pc),
        .p_instr_i       (p_instr),
        .p_cond_taken_i  (p_cond_taken),
        .pred_taken_i    (p_pred_taken),
        .pred_target_i   (p_pred_target),
        .btb_hit_i       (p_btb_hit),
        .pht_index_i     (p_pht_index),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_pc_o        (out_pc_o),
        .pred_taken_o    (pred_taken_o),
        .pred_target_o   (pred_target_o),
        .actual_taken_o  (actual_taken_o),
        .actual_target_o (actual_target_o),
        .mispredict_o    (mispredict_o),
        .btb_we_o        (btb_we),
        .btb_wr_pc_o     (btb_wr_pc),
        .btb_wr_kind_o   (btb_wr_kind),
        .btb_wr_target_o (btb_wr_target),
        .pht_we_o        (pht_we),
        .pht_wr_index_o  (pht_wr_index),
        .pht_inc_o       (pht_inc)
    );

endmodule

/* hdl/resolve_stage.sv */
// Resolution pipeline stage
`timescale 1ns/10ps

module resolve_stage #(
    parameter int NUM_GHR_BITS = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    // From predict stage
    input  logic                    p_valid_i,
    output logic                    p_ready_o,
    input  logic [31:0]             p_pc_i,
    input  logic [31:0]             p_instr_i,
    input  logic                    p_cond_taken_i,
    input  logic                    pred_taken_i,
    input  logic [31:0]             pred_target_i,
    input  logic                    btb_hit_i,
    input  logic [NUM_GHR_BITS-1:0] pht_index_i,
    // Result output
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output logic [31:0]             out_pc_o,
    output logic                    pred_taken_o,
    output logic [31:0]             pred_target_o,
    output logic                    actual_taken_o,
    output logic [31:0]             actual_target_o,
    output logic                    mispredict_o,
    // Training back to predict stage
    output logic                    btb_we_o,
    output logic [31:0]             btb_wr_pc_o,
    output bpu_pkg::btb_kind_e      btb_wr_kind_o,
    output logic [31:0]             btb_wr_target_o,
    output logic                    pht_we_o,
    output logic [NUM_GHR_BITS-1:0] pht_wr_index_o,
    output logic                    pht_inc_o
);

    riscv_pkg::instr_u instr;
    logic [31:0]       b_imm;
    logic [31:0]       j_imm;
    logic              is_branch;
    logic              is_jal;
    logic              actual_taken;
    logic [31:0]       actual_target;
    logic              mispredict;
    logic              load;

    assign instr = p_instr_i;

    // Sign-extended immediates with bit 0 always zero
    assign b_imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0};
    assign j_imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                    instr.j.imm10_1, 1'b0};

    assign is_branch = (instr.b.opcode == riscv_pkg::OP_BRANCH);
    assign is_jal    = (instr.j.opcode == riscv_pkg::OP_JAL);

    // Actual outcome
    // JALR and everything else count as sequential
    always_comb begin
        if (is_branch) begin
            actual_taken  = p_cond_taken_i;
            actual_target = p_pc_i + b_imm;
        end else if (is_jal) begin
            actual_taken  = 1'b1;
            actual_target = p_pc_i + j_imm;
        end else begin
            actual_taken  = 1'b0;
            actual_target = p_pc_i + 32'd4;
        end
    end

    // Wrong direction, or right direction with a wrong target
    assign mispredict = (pred_taken_i != actual_taken) ||
                        (pred_taken_i && actual_taken && (pred_target_i != actual_target));

    assign p_ready_o = !out_valid_o || out_ready_i;
    assign load      = p_valid_i && p_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (p_ready_o) begin
            out_valid_o <= p_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_pc_o        <= p_pc_i;
            pred_taken_o    <= pred_taken_i;
            pred_target_o   <= pred_target_i;
            actual_taken_o  <= actual_taken;
            actual_target_o <= actual_target;
            mispredict_o    <= mispredict;
        end
    end

    // Allocate only taken control transfers that missed
    assign btb_we_o        = load && actual_taken && (is_branch || is_jal) && !btb_hit_i;
    assign btb_wr_pc_o     = p_pc_i;
    assign btb_wr_target_o = actual_target;
    assign btb_wr_kind_o   = is_jal ? bpu_pkg::BTB_JUMP : bpu_pkg::BTB_BRANCH;

    // Counter and history follow every conditional branch
    assign pht_we_o       = load && is_branch;
    assign pht_wr_index_o = pht_index_i;
    assign pht_inc_o      = actual_taken;

endmodule

/* hdl/predict_stage.sv */
// Prediction pipeline stage
`timescale 1ns/10ps

module predict_stage #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    // Record input
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  logic [31:0]             pc_i,
    input  logic [31:0]             instr_i,
    input  logic                    cond_taken_i,
    // Toward resolve stage
    output logic                    p_valid_o,
    input  logic                    p_ready_i,
    output logic [31:0]             p_pc_o,
    output logic [31:0]             p_instr_o,
    output logic                    p_cond_taken_o,
    output logic                    pred_taken_o,
    output logic [31:0]             pred_target_o,
    output logic                    btb_hit_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    // Training from resolve stage
    input  logic                    btb_we_i,
    input  logic [31:0]             btb_wr_pc_i,
    input  bpu_pkg::btb_kind_e      btb_wr_kind_i,
    input  logic [31:0]             btb_wr_target_i,
    input  logic                    pht_we_i,
    input  logic [NUM_GHR_BITS-1:0] pht_wr_index_i,
    input  logic                    pht_inc_i
);

    logic                    btb_hit;
    bpu_pkg::btb_kind_e      btb_kind;
    logic [31:0]             btb_target;
    logic [NUM_GHR_BITS-1:0] pht_index;
    logic                    pht_taken;
    logic                    pred_taken;
    logic [31:0]             pred_target;
    logic                    load;

    btb #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES)
    ) i_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_pc_i     (pc_i),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target),
        .we_i        (btb_we_i),
        .wr_pc_i     (btb_wr_pc_i),
        .wr_kind_i   (btb_wr_kind_i),
        .wr_target_i (btb_wr_target_i)
    );

    gshare #(
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) i_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .rd_pc_i         (pc_i),
        .index_o         (pht_index),
        .predict_taken_o (pht_taken),
        .we_i            (pht_we_i),
        .wr_index_i      (pht_wr_index_i),
        .inc_i           (pht_inc_i)
    );

    // Prediction for the incoming PC
    // Miss falls through to the next word
    always_comb begin
        if (btb_hit) begin
            pred_taken  = (btb_kind == bpu_pkg::BTB_JUMP) ? 1'b1 : pht_taken;
            pred_target = btb_target;
        end else begin
            pred_taken  = 1'b0;
            pred_target = pc_i + 32'd4;
        end
    end

    // Room when empty or when the held record leaves this edge
    assign in_ready_o = !p_valid_o || p_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            p_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            p_valid_o <= in_valid_i;
        end
    end

    // Record with its prediction and the counter it used
    always_ff @(posedge clk) begin
        if (load) begin
            p_pc_o         <= pc_i;
            p_instr_o      <= instr_i;
            p_cond_taken_o <= cond_taken_i;
            pred_taken_o   <= pred_taken;
            pred_target_o  <= pred_target;
            btb_hit_o      <= btb_hit;
            pht_index_o    <= pht_index;
        end
    end

endmodule

/* hdl/gshare.sv */
// Gshare direction predictor
`timescale 1ns/10ps

module gshare #(
    parameter int NUM_GHR_BITS = 4
) (
    input  logic                    clk,
    input  logic                    reset_i,
    // Lookup port
    input  logic [31:0]             rd_pc_i,
    output logic [NUM_GHR_BITS-1:0] index_o,
    output logic                    predict_taken_o,
    // Training port
    input  logic                    we_i,
    input  logic [NUM_GHR_BITS-1:0] wr_index_i,
    input  logic                    inc_i
);

    localparam int NUM_CTRS = 2 ** NUM_GHR_BITS;

    logic [NUM_GHR_BITS-1:0] ghr_q;
    bpu_pkg::ctr_t           pht_q [NUM_CTRS];

    // Word address bits hashed with global history
    assign index_o = rd_pc_i[NUM_GHR_BITS+1:2] ^ ghr_q;

    // Counter MSB gives the direction
    assign predict_taken_o = pht_q[index_o][1];

    // Counters and history
    // Both move only on a resolved conditional branch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
            for (int i = 0; i < NUM_CTRS; i++) begin
                pht_q[i] <= bpu_pkg::CTR_RESET;
            end
        end else if (we_i) begin
            // Saturate at both ends
            if (inc_i && (pht_q[wr_index_i] != 2'b11)) begin
                pht_q[wr_index_i] <= pht_q[wr_index_i] + 2'b01;
            end else if (!inc_i && (pht_q[wr_index_i] != 2'b00)) begin
                pht_q[wr_index_i] <= pht_q[wr_index_i] - 2'b01;
            end
            // Newest outcome enters at the MSB
            ghr_q <= {inc_i, ghr_q[NUM_GHR_BITS-1:1]};
        end
    end

endmodule

/* hdl/btb.sv */
// Branch target buffer
`timescale 1ns/10ps

module btb #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                 clk,
    input  logic                 reset_i,
    // Lookup port
    input  logic [31:0]          rd_pc_i,
    output logic                 hit_o,
    output bpu_pkg::btb_kind_e   kind_o,
    output logic [31:0]          target_o,
    // Fill port
    input  logic                 we_i,
    input  logic [31:0]          wr_pc_i,
    input  bpu_pkg::btb_kind_e   wr_kind_i,
    input  logic [31:0]          wr_target_i
);

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);
    // PC bits above the index, word offset dropped
    localparam int TAG_BITS = 30 - IDX_BITS;

    logic [NUM_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_BITS-1:0]        tags_q    [NUM_BTB_ENTRIES];
    bpu_pkg::btb_kind_e         kinds_q   [NUM_BTB_ENTRIES];
    logic [31:0]                targets_q [NUM_BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    logic [IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] wr_tag;

    // Split both PCs into index and tag
    assign rd_idx = rd_pc_i[IDX_BITS+1:2];
    assign rd_tag = rd_pc_i[31:IDX_BITS+2];
    assign wr_idx = wr_pc_i[IDX_BITS+1:2];
    assign wr_tag = wr_pc_i[31:IDX_BITS+2];

    // Combinational lookup
    // Hit needs a valid entry with a matching tag
    assign hit_o    = valid_q[rd_idx] && (tags_q[rd_idx] == rd_tag);
    assign kind_o   = kinds_q[rd_idx];
    assign target_o = targets_q[rd_idx];

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry contents
    // A fill simply replaces whatever was there
    always_ff @(posedge clk) begin
        if (we_i) begin
            tags_q[wr_idx]    <= wr_tag;
            kinds_q[wr_idx]   <= wr_kind_i;
            targets_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

/* hdl/bpu_pkg.sv */
// Branch predictor types
package bpu_pkg;

    // Two-bit saturating counter
    // MSB set means predict taken
    typedef logic [1:0] ctr_t;

    // Weakly not taken
    localparam ctr_t CTR_RESET = 2'b01;

    // What a BTB entry holds
    // Jumps are always taken while branches ask the counters
    typedef enum logic {
        BTB_BRANCH = 1'b0,
        BTB_JUMP   = 1'b1
    } btb_kind_e;

endpackage

/* hdl/riscv_pkg.sv */
// RISC-V instruction formats
package riscv_pkg;

    // Major opcodes used by the branch unit
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Conditional branch layout
    // Immediate bit 0 is implicit zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    // Unconditional jump layout
    // Immediate is scrambled across the upper 20 bits
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word seen either as B-type or as J-type
    // Opcode sits in bits 6:0 of both views
    typedef union packed {
        b_type_t b;
        j_type_t j;
    } instr_u;

endpackage
